// ==== Bender.yml ====
package:
  name: serial_slave

sources:
  # packages first, then the blocks, then the top level
  - files:
      - hdl/bus_pkg.sv
      - hdl/slave_pkg.sv
      - hdl/frame_receiver.sv
      - hdl/write_deserializer.sv
      - hdl/slave_controller.sv
      - hdl/slave_ram.sv
      - hdl/read_serializer.sv
      - hdl/serial_slave.sv

  - target: simulation
    files:
      - sim/serial_slave_tb.sv

// ==== hdl/bus_pkg.sv ====
/*
 * bus_pkg
 * serial bus frame format seen on the control line
 * start code, field widths, read/write opcode and the frame layout
 * in wire order, MSB first
 */
`default_nettype none

package bus_pkg;

    // every frame opens with this code
    localparam logic [2:0] START_CODE = 3'b111;

    // field widths
    localparam int ID_WIDTH   = 2;
    localparam int ADDR_WIDTH = 11;

    // start + id + rw + burst + addr
    localparam int FRAME_LEN = 3 + ID_WIDTH + 2 + ADDR_WIDTH;

    // read/write bit of the frame, 1 means write
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // first field is the first bit on the wire
    typedef struct packed {
        logic [2:0]            start;
        logic [ID_WIDTH-1:0]   id;
        bus_op_e               op;
        logic                  burst;
        logic [ADDR_WIDTH-1:0] addr;
    } frame_t;

endpackage

`default_nettype wire

// ==== hdl/frame_receiver.sv ====
/*
 * frame_receiver
 * shifts the configuration frame in from control, MSB first
 * checks start code and slave id, then pulses req_valid with the
 * decoded request; mismatching frames are dropped
 */
`timescale 1ns/1ps
`default_nettype none

module frame_receiver #(
    parameter int unsigned SLAVE_ID = 1
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                control,
    input  logic                busy,
    output slave_pkg::request_t req,
    output logic                req_valid
);

    localparam int CNT_W = $clog2(bus_pkg::FRAME_LEN);
    localparam logic [bus_pkg::ID_WIDTH-1:0] OWN_ID = SLAVE_ID[bus_pkg::ID_WIDTH-1:0];

    bus_pkg::frame_t  frame_q;
    bus_pkg::frame_t  frame_next;
    logic [CNT_W-1:0] bit_cnt;
    logic             receiving;
    logic             start;
    logic             last_bit;
    logic             match;

    // a high bit on an idle line is frame bit 1
    assign start      = !receiving && !busy && !req_valid && control;
    assign last_bit   = receiving && (bit_cnt == CNT_W'(bus_pkg::FRAME_LEN - 1));
    // frame including this cycle's bit
    assign frame_next = {frame_q[bus_pkg::FRAME_LEN-2:0], control};
    assign match      = (frame_next.start == bus_pkg::START_CODE) && (frame_next.id == OWN_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            receiving <= 1'b0;
            bit_cnt   <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= last_bit && match;
            if (start) begin
                receiving <= 1'b1;
                bit_cnt   <= CNT_W'(1);
            end else if (last_bit) begin
                // back to waiting whether or not the frame matched
                receiving <= 1'b0;
                bit_cnt   <= '0;
            end else if (receiving) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // frame and request payload
    always_ff @(posedge clk) begin
        if (start || receiving) begin
            frame_q <= frame_next;
        end
        if (last_bit) begin
            req.op    <= frame_next.op;
            req.burst <= frame_next.burst;
            req.addr  <= frame_next.addr;
        end
    end

    // a new request only reaches an idle controller
    a_req_not_busy: assert property (@(posedge clk) disable iff (!rstN)
        $rose(req_valid) |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/read_serializer.sv ====
/*
 * read_serializer
 * takes a word on load and drives it out on rD, MSB first,
 * one bit per cycle; done pulses the cycle after the last bit
 */
`timescale 1ns/1ps
`default_nettype none

module read_serializer #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  load,
    input  logic [DATA_WIDTH-1:0] rdata,
    output logic                  rD,
    output logic                  shifting,
    output logic                  done
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] shift_q;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  final_bit;

    assign final_bit = shifting && (bit_cnt == CNT_W'(DATA_WIDTH - 1));
    // line rests low between words
    assign rD        = shifting && shift_q[DATA_WIDTH-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shifting <= 1'b0;
            done     <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            done <= final_bit;
            if (load) begin
                shifting <= 1'b1;
                bit_cnt  <= '0;
            end else if (final_bit) begin
                shifting <= 1'b0;
                bit_cnt  <= '0;
            end else if (shifting) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= rdata;
        end else if (shifting) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // controller only fetches once the previous word is out
    a_no_load_while_shifting: assert property (@(posedge clk) disable iff (!rstN)
        load |-> !shifting);

endmodule

`default_nettype wire

// ==== hdl/serial_slave.sv ====
/*
 * serial_slave
 * top level of the serial bus slave
 * frame receiver, write deserializer, transfer controller,
 * word RAM and read serializer
 */
`timescale 1ns/1ps
`default_nettype none

module serial_slave #(
    parameter int          DATA_WIDTH = 32,
    parameter int          ADDR_DEPTH = 2000,
    parameter int unsigned SLAVE_ID   = 1,
    parameter int          READ_DELAY = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    slave_pkg::request_t            req;
    logic                           req_valid;
    logic                           busy;
    logic                           wr_enable;
    logic [DATA_WIDTH-1:0]          word;
    logic                           word_valid;
    logic                           word_last;
    logic                           we;
    logic [bus_pkg::ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]          wdata;
    logic [DATA_WIDTH-1:0]          rdata;
    logic                           load;
    logic                           shifting;
    logic                           done;

    // input side
    frame_receiver #(
        .SLAVE_ID (SLAVE_ID)
    ) u_frame_receiver (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .busy      (busy),
        .req       (req),
        .req_valid (req_valid)
    );

    write_deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_write_deserializer (
        .clk        (clk),
        .rstN       (rstN),
        .wr_enable  (wr_enable),
        .wD         (wD),
        .valid      (valid),
        .last       (last),
        .word       (word),
        .word_valid (word_valid),
        .word_last  (word_last)
    );

    // processing
    slave_controller #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_DEPTH (ADDR_DEPTH),
        .READ_DELAY (READ_DELAY)
    ) u_slave_controller (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .req_valid  (req_valid),
        .word       (word),
        .word_valid (word_valid),
        .word_last  (word_last),
        .last       (last),
        .shifting   (shifting),
        .done       (done),
        .busy       (busy),
        .wr_enable  (wr_enable),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .load       (load),
        .ready      (ready)
    );

    slave_ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_DEPTH (ADDR_DEPTH)
    ) u_slave_ram (
        .clk   (clk),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata)
    );

    // output side
    read_serializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_read_serializer (
        .clk      (clk),
        .rstN     (rstN),
        .load     (load),
        .rdata    (rdata),
        .rD       (rD),
        .shifting (shifting),
        .done     (done)
    );

endmodule

`default_nettype wire

// ==== hdl/slave_controller.sv ====
/*
 * slave_controller
 * transfer FSM of the serial slave
 * holds the transfer address, counts the read delay, fetches
 * read words from RAM into the serializer and drives ready
 */
`timescale 1ns/1ps
`default_nettype none

module slave_controller #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_DEPTH = 2000,
    parameter int READ_DELAY = 2
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  slave_pkg::request_t            req,
    input  logic                           req_valid,
    input  logic [DATA_WIDTH-1:0]          word,
    input  logic                           word_valid,
    input  logic                           word_last,
    input  logic                           last,
    input  logic                           shifting,
    input  logic                           done,
    output logic                           busy,
    output logic                           wr_enable,
    output logic                           we,
    output logic [bus_pkg::ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0]          wdata,
    output logic                           load,
    output logic                           ready
);

    localparam int DLY_W = (READ_DELAY > 1) ? $clog2(READ_DELAY) : 1;

    slave_pkg::ctrl_state_e         state_q;
    logic [bus_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [DLY_W-1:0]               dly_cnt;
    logic                           burst_q;
    logic                           last_seen;
    logic                           read_req;
    logic                           stop_read;

    assign read_req  = req_valid && (req.op == bus_pkg::OP_READ);
    // last may arrive on the done cycle itself
    assign stop_read = !burst_q || last_seen || last;

    assign busy      = (state_q != slave_pkg::IDLE);
    assign wr_enable = (state_q == slave_pkg::WRITE_DATA);
    // RAM write on the word_valid cycle
    assign we        = wr_enable && word_valid;
    assign addr      = addr_q;
    assign wdata     = word;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state_q   <= slave_pkg::IDLE;
            addr_q    <= '0;
            dly_cnt   <= '0;
            burst_q   <= 1'b0;
            last_seen <= 1'b0;
            load      <= 1'b0;
        end else begin
            load <= 1'b0;
            unique case (state_q)
                slave_pkg::IDLE: begin
                    dly_cnt <= '0;
                    if (req_valid) begin
                        addr_q  <= req.addr;
                        burst_q <= req.burst;
                        if (req.op == bus_pkg::OP_WRITE) begin
                            state_q <= slave_pkg::WRITE_DATA;
                        end else if (READ_DELAY == 0) begin
                            state_q <= slave_pkg::READ_FETCH;
                        end else begin
                            state_q <= slave_pkg::READ_WAIT;
                        end
                    end
                end
                slave_pkg::WRITE_DATA: begin
                    if (word_valid) begin
                        if (!burst_q || word_last) begin
                            state_q <= slave_pkg::IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                slave_pkg::READ_WAIT: begin
                    if (dly_cnt == DLY_W'(READ_DELAY - 1)) begin
                        state_q <= slave_pkg::READ_FETCH;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                slave_pkg::READ_FETCH: begin
                    // rdata valid next cycle, load goes with it
                    load      <= 1'b1;
                    last_seen <= 1'b0;
                    state_q   <= slave_pkg::READ_SHIFT;
                end
                slave_pkg::READ_SHIFT: begin
                    if (last) begin
                        last_seen <= 1'b1;
                    end
                    if (done) begin
                        if (stop_read) begin
                            state_q <= slave_pkg::IDLE;
                        end else begin
                            addr_q  <= addr_q + 1'b1;
                            state_q <= slave_pkg::READ_GAP;
                        end
                    end
                end
                slave_pkg::READ_GAP: begin
                    state_q <= slave_pkg::READ_FETCH;
                end
                default: begin
                    state_q <= slave_pkg::IDLE;
                end
            endcase
        end
    end

    // ready drops with a read request and comes back with the first bit
    always_comb begin
        unique case (state_q)
            slave_pkg::IDLE:       ready = !read_req;
            slave_pkg::WRITE_DATA: ready = 1'b1;
            slave_pkg::READ_SHIFT: ready = shifting;
            default:               ready = 1'b0;
        endcase
    end

    // frame address must stay inside the memory for the whole transfer
    a_addr_range: assert property (@(posedge clk) disable iff (!rstN)
        (we || state_q == slave_pkg::READ_FETCH) |-> (addr < ADDR_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/slave_pkg.sv ====
/*
 * slave_pkg
 * internal types of the serial slave
 * controller states and the request handed from the frame
 * receiver to the transfer controller
 */
`default_nettype none

package slave_pkg;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_DATA,
        READ_WAIT,
        READ_FETCH,
        READ_SHIFT,
        READ_GAP
    } ctrl_state_e;

    // accepted frame, id and start code already checked
    typedef struct packed {
        bus_pkg::bus_op_e              op;
        logic                          burst;
        logic [bus_pkg::ADDR_WIDTH-1:0] addr;
    } request_t;

endpackage

`default_nettype wire

// ==== hdl/slave_ram.sv ====
/*
 * slave_ram
 * word memory of the slave
 * synchronous write, read data registered one cycle after addr
 */
`timescale 1ns/1ps
`default_nettype none

module slave_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_DEPTH = 2000
) (
    input  logic                           clk,
    input  logic                           we,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0]          wdata,
    output logic [DATA_WIDTH-1:0]          rdata
);

    logic [DATA_WIDTH-1:0] mem [ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        // old data on a same-cycle write
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/write_deserializer.sv ====
/*
 * write_deserializer
 * collects wD bits MSB first on cycles with valid high and
 * presents each finished word for one cycle, together with the
 * last flag seen on its final bit
 */
`timescale 1ns/1ps
`default_nettype none

module write_deserializer #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wr_enable,
    input  logic                  wD,
    input  logic                  valid,
    input  logic                  last,
    output logic [DATA_WIDTH-1:0] word,
    output logic                  word_valid,
    output logic                  word_last
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] shift_q;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  sample;
    logic                  final_bit;

    assign sample    = wr_enable && valid;
    assign final_bit = sample && (bit_cnt == CNT_W'(DATA_WIDTH - 1));
    // full word sits in the shifter while word_valid is high
    assign word      = shift_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            word_valid <= final_bit;
            if (!wr_enable || final_bit) begin
                bit_cnt <= '0;
            end else if (sample) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (final_bit) begin
                word_last <= last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], wD};
        end
    end

endmodule

`default_nettype wire

// ==== sim/serial_slave_tb.sv ====
/*
 * serial_slave_tb
 * table-driven testbench for the serial bus slave
 * drives frames and write words on the falling edge, collects
 * read words from rD and checks them against a reference memory
 */
`timescale 1ns/1ps
`default_nettype none

module serial_slave_tb;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_DEPTH = 2000;
    localparam int SLAVE_ID   = 1;
    localparam int READ_DELAY = 2;
    localparam int NAME_W     = 8 * 12;
    localparam int NUM_TESTS  = 8;

    // one row of the stimulus table
    typedef struct packed {
        logic [NAME_W-1:0]              name;
        logic [bus_pkg::ID_WIDTH-1:0]   id;
        bus_pkg::bus_op_e               op;
        logic                           burst;
        logic [bus_pkg::ADDR_WIDTH-1:0] addr;
        logic [3:0]                     words;
        logic                           gap;
    } row_t;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    row_t                  tests [NUM_TESTS];
    logic [DATA_WIDTH-1:0] ref_mem [ADDR_DEPTH];
    integer                seed;
    int                    err_cnt;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    cycles;
    int                    cycle_limit;

    serial_slave #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_DEPTH (ADDR_DEPTH),
        .SLAVE_ID   (SLAVE_ID),
        .READ_DELAY (READ_DELAY)
    ) u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic row_t make_row(input logic [NAME_W-1:0] name,
                                      input logic [bus_pkg::ID_WIDTH-1:0] id,
                                      input bus_pkg::bus_op_e op,
                                      input logic burst,
                                      input logic [bus_pkg::ADDR_WIDTH-1:0] addr,
                                      input logic [3:0] words,
                                      input logic gap);
        row_t row;
        row.name  = name;
        row.id    = id;
        row.op    = op;
        row.burst = burst;
        row.addr  = addr;
        row.words = words;
        row.gap   = gap;
        return row;
    endfunction

    // worst case length of one row with frame, idle, gapped data, delay and settle
    function automatic int row_cycles(input row_t row);
        int per_word;
        per_word = DATA_WIDTH * (row.gap ? 2 : 1) + READ_DELAY + 5;
        return bus_pkg::FRAME_LEN + 7 + row.words * per_word;
    endfunction

    task automatic check_word(input logic [NAME_W-1:0] name,
                              input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("** Error %0s: read word expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_ready(input logic [NAME_W-1:0] name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %0s: ready expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_rd(input logic [NAME_W-1:0] name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %0s: rD expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    // one falling edge where an idle or writing slave keeps ready high
    task automatic cycle_ready_high(input logic [NAME_W-1:0] name);
        @(negedge clk);
        check_ready(name, 1'b1, ready);
    endtask

    // frame bits MSB first with the last bit held on control until the next task
    task automatic send_frame(input row_t row);
        bus_pkg::frame_t               frame;
        logic [bus_pkg::FRAME_LEN-1:0] bits;
        frame.start = bus_pkg::START_CODE;
        frame.id    = row.id;
        frame.op    = row.op;
        frame.burst = row.burst;
        frame.addr  = row.addr;
        bits        = frame;
        for (int i = bus_pkg::FRAME_LEN - 1; i >= 0; i--) begin
            cycle_ready_high(row.name);
            control = bits[i];
        end
    endtask

    task automatic write_words(input row_t row);
        logic [DATA_WIDTH-1:0] data;
        logic                  accept;
        accept = (row.id == SLAVE_ID);
        // req_valid and the move to WRITE_DATA take two cycles
        repeat (2) begin
            cycle_ready_high(row.name);
            control = 1'b0;
        end
        for (int w = 0; w < row.words; w++) begin
            data = $random(seed);
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                if (row.gap && ($random(seed) & 1)) begin
                    // stall cycle with a wrong bit on wD
                    cycle_ready_high(row.name);
                    valid = 1'b0;
                    wD    = ~data[b];
                    last  = 1'b0;
                end
                cycle_ready_high(row.name);
                valid = 1'b1;
                wD    = data[b];
                last  = (w == row.words - 1) && (b == 0);
            end
            if (accept) begin
                ref_mem[row.addr + w] = data;
            end
        end
        cycle_ready_high(row.name);
        valid = 1'b0;
        wD    = 1'b0;
        last  = 1'b0;
    endtask

    task automatic read_words(input row_t row);
        logic [DATA_WIDTH-1:0] got;
        int                    low_cycles;
        for (int w = 0; w < row.words; w++) begin
            low_cycles = 0;
            @(negedge clk);
            control = 1'b0;
            // end of read latency or of the gap between words
            while (ready !== 1'b1) begin
                low_cycles++;
                @(negedge clk);
            end
            // request cycle, delay, fetch and serializer load
            if (w == 0 && low_cycles != READ_DELAY + 3) begin
                $display("** Error %0s: read latency expected %0d low cycles, actual %0d",
                         row.name, READ_DELAY + 3, low_cycles);
                err_cnt++;
            end
            if (w > 0 && low_cycles < 1) begin
                $display("%0s: ready did not drop between burst words", row.name);
                err_cnt++;
            end
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                if (b != DATA_WIDTH - 1) begin
                    @(negedge clk);
                    check_ready(row.name, 1'b1, ready);
                end
                got[b] = rD;
                // sticky last during the final burst word
                last = row.burst && (w == row.words - 1) && (b != 0);
            end
            check_word(row.name, ref_mem[row.addr + w], got);
        end
    endtask

    task automatic report_test(input logic [NAME_W-1:0] name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%0s: ok", name);
        end else begin
            fail_cnt++;
            $display("%0s: FAIL with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // run limit from the table length
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles without finishing the tests", cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errs_before;
        int total;
        rstN     = 1'b0;
        control  = 1'b0;
        wD       = 1'b0;
        valid    = 1'b0;
        last     = 1'b0;
        seed     = 32'hfbd867de;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;

        tests[0] = make_row("single_write", 2'd1, bus_pkg::OP_WRITE, 1'b0, 11'd5, 4'd1, 1'b0);
        tests[1] = make_row("single_read", 2'd1, bus_pkg::OP_READ, 1'b0, 11'd5, 4'd1, 1'b0);
        tests[2] = make_row("burst_write", 2'd1, bus_pkg::OP_WRITE, 1'b1, 11'd1996, 4'd4, 1'b0);
        tests[3] = make_row("burst_read", 2'd1, bus_pkg::OP_READ, 1'b1, 11'd1996, 4'd4, 1'b0);
        tests[4] = make_row("stall_write", 2'd1, bus_pkg::OP_WRITE, 1'b0, 11'd7, 4'd1, 1'b1);
        tests[5] = make_row("stall_read", 2'd1, bus_pkg::OP_READ, 1'b0, 11'd7, 4'd1, 1'b0);
        // wrong id carries new data for address 5, which must be dropped
        tests[6] = make_row("wrong_id", 2'd2, bus_pkg::OP_WRITE, 1'b0, 11'd5, 4'd1, 1'b0);
        tests[7] = make_row("old_read", 2'd1, bus_pkg::OP_READ, 1'b0, 11'd5, 4'd1, 1'b0);

        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += row_cycles(tests[t]);
        end
        cycle_limit = 2 * total + 8 + 4;

        repeat (8) @(negedge clk);
        rstN = 1'b1;

        // idle slave right after reset
        errs_before = err_cnt;
        @(negedge clk);
        check_ready("reset", 1'b1, ready);
        check_rd("reset", 1'b0, rD);
        report_test("reset", errs_before);

        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_cnt;
            send_frame(tests[t]);
            if (tests[t].op == bus_pkg::OP_WRITE) begin
                write_words(tests[t]);
            end else begin
                read_words(tests[t]);
            end
            // let the controller fall back to IDLE
            repeat (4) @(negedge clk);
            report_test(tests[t].name, errs_before);
        end

        $display("tests: %0d ok, %0d with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/bus_pkg.sv
hdl/slave_pkg.sv
hdl/frame_receiver.sv
hdl/write_deserializer.sv
hdl/slave_controller.sv
hdl/slave_ram.sv
hdl/read_serializer.sv
hdl/serial_slave.sv
sim/serial_slave_tb.sv
